// ==== include/accel_wrapper_config.svh ====
`ifndef ACCEL_WRAPPER_CONFIG_SVH
`define ACCEL_WRAPPER_CONFIG_SVH

// line geometry
`define ACW_LINE_BYTES       16
`define ACW_LINE_BITS        128
`define ACW_LINE_ADDR_W      28
`define ACW_TAG_W            8
`define ACW_WORDS_PER_LINE   4

// scratchpad window, 16 KB at the top of the map
`define ACW_LOCAL_BASE       32'hF000_0000
`define ACW_LOCAL_BITS       14
`define ACW_SRAM_DEPTH       1024

// control/status byte offsets
`define ACW_CSR_BUSY_OFS     32'h0
`define ACW_CSR_START_OFS    32'h4
`define ACW_CSR_PC_OFS       32'h8

// accelerator boots from the scratchpad
`define ACW_PC_RESET_DEFAULT `ACW_LOCAL_BASE

`endif

// ==== rtl/accel_wrapper_pkg.sv ====
`include "accel_wrapper_config.svh"

package accel_wrapper_pkg;

    ////////////////////////////////////////
    // host side
    ////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;

    ////////////////////////////////////////
    // accelerator side
    ////////////////////////////////////////

    typedef logic [`ACW_LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [`ACW_LINE_BYTES-1:0]  byteen_t;
    typedef logic [`ACW_TAG_W-1:0]       tag_t;
    typedef logic [$clog2(`ACW_SRAM_DEPTH)-1:0] sram_index_t;

    // one line, seen whole by the accelerator or as words by the host
    typedef union packed
    {
        logic [`ACW_LINE_BITS-1:0]             raw;
        word_t [`ACW_WORDS_PER_LINE-1:0]       words;
    } line_t;

endpackage

// ==== rtl/local_sram.sv ====
`timescale 1ns/100ps
`include "accel_wrapper_config.svh"

module local_sram
(
    input  logic                            clk,
    input  logic                            en,
    input  logic                            we,
    input  accel_wrapper_pkg::byteen_t      byteen,
    input  accel_wrapper_pkg::sram_index_t  index,
    input  accel_wrapper_pkg::line_t        wdata,
    output accel_wrapper_pkg::line_t        rdata
);

    ////////////////////////////////////////
    // line array
    ////////////////////////////////////////

    accel_wrapper_pkg::line_t mem [`ACW_SRAM_DEPTH];

    // per-byte write
    always_ff @(posedge clk)
    begin
        if (en && we)
        begin
            for (int b = 0; b < `ACW_LINE_BYTES; b++)
            begin
                if (byteen[b])
                    mem[index].raw[b*8 +: 8] <= wdata.raw[b*8 +: 8];
            end
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk)
    begin
        if (en && !we)
            rdata <= mem[index];
    end

endmodule

// ==== rtl/mem_port_router.sv ====
`timescale 1ns/100ps
`include "accel_wrapper_config.svh"

module mem_port_router
(
    input  logic                            clk,
    input  logic                            nRST,
    // accelerator request
    input  logic                            acc_req_valid,
    input  logic                            acc_req_rw,
    input  accel_wrapper_pkg::byteen_t      acc_req_byteen,
    input  accel_wrapper_pkg::line_addr_t   acc_req_addr,
    input  accel_wrapper_pkg::line_t        acc_req_data,
    input  accel_wrapper_pkg::tag_t         acc_req_tag,
    output logic                            acc_req_ready,
    // accelerator response
    output logic                            acc_rsp_valid,
    output accel_wrapper_pkg::line_t        acc_rsp_data,
    output accel_wrapper_pkg::tag_t         acc_rsp_tag,
    input  logic                            acc_rsp_ready,
    // external target
    output logic                            ext_req_valid,
    output logic                            ext_req_rw,
    output accel_wrapper_pkg::byteen_t      ext_req_byteen,
    output accel_wrapper_pkg::line_addr_t   ext_req_addr,
    output accel_wrapper_pkg::line_t        ext_req_data,
    output accel_wrapper_pkg::tag_t         ext_req_tag,
    input  logic                            ext_req_ready,
    input  logic                            ext_rsp_valid,
    input  accel_wrapper_pkg::line_t        ext_rsp_data,
    input  accel_wrapper_pkg::tag_t         ext_rsp_tag,
    output logic                            ext_rsp_ready,
    // scratchpad side, through the arbiter
    output logic                            loc_req_valid,
    output logic                            loc_req_rw,
    output accel_wrapper_pkg::byteen_t      loc_req_byteen,
    output accel_wrapper_pkg::sram_index_t  loc_req_index,
    output accel_wrapper_pkg::line_t        loc_req_data,
    output accel_wrapper_pkg::tag_t         loc_req_tag,
    input  logic                            loc_req_ready,
    input  logic                            loc_rsp_valid,
    input  accel_wrapper_pkg::line_t        loc_rsp_data,
    input  accel_wrapper_pkg::tag_t         loc_rsp_tag,
    output logic                            loc_rsp_ready
);

    localparam int          OFS_BITS   = $clog2(`ACW_LINE_BYTES);
    localparam logic [31:0] LOCAL_BASE = `ACW_LOCAL_BASE;

    logic                           in_window;
    logic                           buf_valid;
    accel_wrapper_pkg::line_t       buf_data;
    accel_wrapper_pkg::tag_t        buf_tag;

    ////////////////////////////////////////
    // request steering
    ////////////////////////////////////////

    // line address upper bits against window base
    assign in_window = acc_req_addr[`ACW_LINE_ADDR_W-1:`ACW_LOCAL_BITS-OFS_BITS] ==
                       LOCAL_BASE[31:`ACW_LOCAL_BITS];

    assign loc_req_valid  = acc_req_valid & in_window;
    assign loc_req_rw     = acc_req_rw;
    assign loc_req_byteen = acc_req_byteen;
    assign loc_req_index  = acc_req_addr[`ACW_LOCAL_BITS-OFS_BITS-1:0];
    assign loc_req_data   = acc_req_data;
    assign loc_req_tag    = acc_req_tag;

    assign ext_req_valid  = acc_req_valid & ~in_window;
    assign ext_req_rw     = acc_req_rw;
    assign ext_req_byteen = acc_req_byteen;
    assign ext_req_addr   = acc_req_addr;
    assign ext_req_data   = acc_req_data;
    assign ext_req_tag    = acc_req_tag;

    // ready of whichever target was picked
    assign acc_req_ready = in_window ? loc_req_ready : ext_req_ready;

    ////////////////////////////////////////
    // response merge
    ////////////////////////////////////////

    // priority: buffer, scratchpad, external
    assign acc_rsp_valid = buf_valid | loc_rsp_valid | ext_rsp_valid;
    assign acc_rsp_data  = buf_valid ? buf_data :
                           loc_rsp_valid ? loc_rsp_data : ext_rsp_data;
    assign acc_rsp_tag   = buf_valid ? buf_tag :
                           loc_rsp_valid ? loc_rsp_tag : ext_rsp_tag;

    assign loc_rsp_ready = acc_rsp_ready & ~buf_valid;
    // ext goes to buffer on collision, else straight through
    assign ext_rsp_ready = ~buf_valid & (loc_rsp_valid | acc_rsp_ready);

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
            buf_valid <= 1'b0;
        else if (buf_valid)
            buf_valid <= ~acc_rsp_ready;
        else
            buf_valid <= loc_rsp_valid & ext_rsp_valid;
    end

    // park external response when scratchpad wins
    always_ff @(posedge clk)
    begin
        if (!buf_valid)
        begin
            buf_data <= ext_rsp_data;
            buf_tag  <= ext_rsp_tag;
        end
    end

endmodule

// ==== rtl/sram_port_arbiter.sv ====
`timescale 1ns/100ps
`include "accel_wrapper_config.svh"

module sram_port_arbiter
(
    input  logic                            clk,
    input  logic                            nRST,
    // accelerator line port from the router
    input  logic                            loc_req_valid,
    input  logic                            loc_req_rw,
    input  accel_wrapper_pkg::byteen_t      loc_req_byteen,
    input  accel_wrapper_pkg::sram_index_t  loc_req_index,
    input  accel_wrapper_pkg::line_t        loc_req_data,
    input  accel_wrapper_pkg::tag_t         loc_req_tag,
    output logic                            loc_req_ready,
    output logic                            loc_rsp_valid,
    output accel_wrapper_pkg::line_t        loc_rsp_data,
    output accel_wrapper_pkg::tag_t         loc_rsp_tag,
    input  logic                            loc_rsp_ready,
    // host word port
    input  logic                            mem_host_req_valid,
    input  logic                            mem_host_req_wen,
    input  accel_wrapper_pkg::word_t        mem_host_req_addr,
    input  accel_wrapper_pkg::word_t        mem_host_req_wdata,
    input  accel_wrapper_pkg::strobe_t      mem_host_req_strobe,
    output logic                            mem_host_req_ready,
    output logic                            mem_host_rsp_valid,
    output accel_wrapper_pkg::word_t        mem_host_rsp_rdata,
    // SRAM port
    output logic                            sram_en,
    output logic                            sram_we,
    output accel_wrapper_pkg::byteen_t      sram_byteen,
    output accel_wrapper_pkg::sram_index_t  sram_index,
    output accel_wrapper_pkg::line_t        sram_wdata,
    input  accel_wrapper_pkg::line_t        sram_rdata
);

    localparam int OFS_BITS  = $clog2(`ACW_LINE_BYTES);
    localparam int LANE_BITS = $clog2(`ACW_WORDS_PER_LINE);
    localparam int LANE_BYTES = `ACW_LINE_BYTES / `ACW_WORDS_PER_LINE;

    logic                       acc_can, grant_acc, grant_host, last_host;
    logic [LANE_BITS-1:0]       host_lane, rd_lane;
    accel_wrapper_pkg::line_t   host_line;
    logic                       rd_acc, rd_host, rsp_full;
    accel_wrapper_pkg::tag_t    rd_tag, rsp_tag;
    accel_wrapper_pkg::line_t   rsp_data;

    ////////////////////////////////////////
    // grant
    ////////////////////////////////////////

    // writes always go, reads only when the response slot frees up
    assign acc_can    = loc_req_valid & (loc_req_rw | ~loc_rsp_valid | loc_rsp_ready);
    assign grant_host = mem_host_req_valid & (~acc_can | ~last_host);
    assign grant_acc  = acc_can & ~grant_host;

    assign loc_req_ready      = grant_acc;
    assign mem_host_req_ready = grant_host;

    // host word into its lane of a line
    assign host_lane = mem_host_req_addr[OFS_BITS-1:2];
    always_comb
    begin
        host_line = '0;
        host_line.words[host_lane] = mem_host_req_wdata;
    end

    assign sram_en     = grant_acc | grant_host;
    assign sram_we     = grant_acc ? loc_req_rw : mem_host_req_wen;
    assign sram_byteen = grant_acc ? loc_req_byteen :
                         accel_wrapper_pkg::byteen_t'(mem_host_req_strobe) <<
                         (host_lane * LANE_BYTES);
    assign sram_index  = grant_acc ? loc_req_index :
                         mem_host_req_addr[`ACW_LOCAL_BITS-1:OFS_BITS];
    assign sram_wdata  = grant_acc ? loc_req_data : host_line;

    ////////////////////////////////////////
    // read return
    ////////////////////////////////////////

    // read stage first, slot holds it under back-pressure
    assign loc_rsp_valid = rsp_full | rd_acc;
    assign loc_rsp_data  = rsp_full ? rsp_data : sram_rdata;
    assign loc_rsp_tag   = rsp_full ? rsp_tag : rd_tag;

    assign mem_host_rsp_valid = rd_host;
    assign mem_host_rsp_rdata = sram_rdata.words[rd_lane];

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            last_host <= 1'b0;
            rd_acc    <= 1'b0;
            rd_host   <= 1'b0;
            rsp_full  <= 1'b0;
        end
        else
        begin
            if (sram_en)
                last_host <= grant_host;
            rd_acc   <= grant_acc & ~loc_req_rw;
            rd_host  <= grant_host & ~mem_host_req_wen;
            rsp_full <= loc_rsp_valid & ~loc_rsp_ready;
        end
    end

    // read owner details, plus the slot payload
    always_ff @(posedge clk)
    begin
        rd_tag  <= loc_req_tag;
        rd_lane <= host_lane;
        if (!rsp_full)
        begin
            rsp_data <= sram_rdata;
            rsp_tag  <= rd_tag;
        end
    end

endmodule

// ==== rtl/ctrl_status_regs.sv ====
`timescale 1ns/100ps
`include "accel_wrapper_config.svh"

module ctrl_status_regs
(
    input  logic                        clk,
    input  logic                        nRST,
    // host CSR port
    input  logic                        csr_host_req_valid,
    input  logic                        csr_host_req_wen,
    input  accel_wrapper_pkg::word_t    csr_host_req_addr,
    input  accel_wrapper_pkg::word_t    csr_host_req_wdata,
    input  accel_wrapper_pkg::strobe_t  csr_host_req_strobe,
    output logic                        csr_host_req_ready,
    output logic                        csr_host_rsp_valid,
    output accel_wrapper_pkg::word_t    csr_host_rsp_rdata,
    // accelerator run control
    input  logic                        acc_busy,
    output logic                        acc_reset,
    output accel_wrapper_pkg::word_t    acc_pc_reset_val
);

    localparam logic [31:0] BUSY_OFS  = `ACW_CSR_BUSY_OFS;
    localparam logic [31:0] START_OFS = `ACW_CSR_START_OFS;
    localparam logic [31:0] PC_OFS    = `ACW_CSR_PC_OFS;

    logic                       busy_q, running;
    logic                       wr_acc, start_hit, pc_hit;
    accel_wrapper_pkg::word_t   pc_q, rd_word;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    // never stalls
    assign csr_host_req_ready = 1'b1;

    assign wr_acc    = csr_host_req_valid & csr_host_req_wen;
    assign pc_hit    = csr_host_req_addr[7:2] == PC_OFS[7:2];
    // write-one on bit 0 only
    assign start_hit = wr_acc & (csr_host_req_addr[7:2] == START_OFS[7:2]) &
                       csr_host_req_strobe[0] & csr_host_req_wdata[0];

    // start reads as zero
    always_comb
    begin
        rd_word = '0;
        if (csr_host_req_addr[7:2] == BUSY_OFS[7:2])
            rd_word[0] = busy_q;
        else if (pc_hit)
            rd_word = pc_q;
    end

    ////////////////////////////////////////
    // registers and run FSM
    ////////////////////////////////////////

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            busy_q             <= 1'b0;
            running            <= 1'b0;
            pc_q               <= `ACW_PC_RESET_DEFAULT;
            csr_host_rsp_valid <= 1'b0;
        end
        else
        begin
            busy_q             <= acc_busy;
            csr_host_rsp_valid <= csr_host_req_valid & ~csr_host_req_wen;
            // held -> running on start, back on busy falling
            if (!running)
                running <= start_hit;
            else if (busy_q && !acc_busy)
                running <= 1'b0;
            if (wr_acc && pc_hit)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (csr_host_req_strobe[b])
                        pc_q[b*8 +: 8] <= csr_host_req_wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        csr_host_rsp_rdata <= rd_word;
    end

    assign acc_reset        = ~nRST | ~running;
    assign acc_pc_reset_val = pc_q;

endmodule

// ==== rtl/accel_mem_wrapper.sv ====
`timescale 1ns/100ps

module accel_mem_wrapper
(
    input  logic                            clk,
    input  logic                            nRST,
    // accelerator line port
    input  logic                            acc_req_valid,
    input  logic                            acc_req_rw,
    input  accel_wrapper_pkg::byteen_t      acc_req_byteen,
    input  accel_wrapper_pkg::line_addr_t   acc_req_addr,
    input  accel_wrapper_pkg::line_t        acc_req_data,
    input  accel_wrapper_pkg::tag_t         acc_req_tag,
    output logic                            acc_req_ready,
    output logic                            acc_rsp_valid,
    output accel_wrapper_pkg::line_t        acc_rsp_data,
    output accel_wrapper_pkg::tag_t         acc_rsp_tag,
    input  logic                            acc_rsp_ready,
    // external line port
    output logic                            ext_req_valid,
    output logic                            ext_req_rw,
    output accel_wrapper_pkg::byteen_t      ext_req_byteen,
    output accel_wrapper_pkg::line_addr_t   ext_req_addr,
    output accel_wrapper_pkg::line_t        ext_req_data,
    output accel_wrapper_pkg::tag_t         ext_req_tag,
    input  logic                            ext_req_ready,
    input  logic                            ext_rsp_valid,
    input  accel_wrapper_pkg::line_t        ext_rsp_data,
    input  accel_wrapper_pkg::tag_t         ext_rsp_tag,
    output logic                            ext_rsp_ready,
    // host scratchpad port
    input  logic                            mem_host_req_valid,
    input  logic                            mem_host_req_wen,
    input  accel_wrapper_pkg::word_t        mem_host_req_addr,
    input  accel_wrapper_pkg::word_t        mem_host_req_wdata,
    input  accel_wrapper_pkg::strobe_t      mem_host_req_strobe,
    output logic                            mem_host_req_ready,
    output logic                            mem_host_rsp_valid,
    output accel_wrapper_pkg::word_t        mem_host_rsp_rdata,
    // host CSR port
    input  logic                            csr_host_req_valid,
    input  logic                            csr_host_req_wen,
    input  accel_wrapper_pkg::word_t        csr_host_req_addr,
    input  accel_wrapper_pkg::word_t        csr_host_req_wdata,
    input  accel_wrapper_pkg::strobe_t      csr_host_req_strobe,
    output logic                            csr_host_req_ready,
    output logic                            csr_host_rsp_valid,
    output accel_wrapper_pkg::word_t        csr_host_rsp_rdata,
    // run control
    input  logic                            acc_busy,
    output logic                            acc_reset,
    output accel_wrapper_pkg::word_t        acc_pc_reset_val
);

    // router to arbiter
    logic                           loc_req_valid, loc_req_rw, loc_req_ready;
    accel_wrapper_pkg::byteen_t     loc_req_byteen;
    accel_wrapper_pkg::sram_index_t loc_req_index;
    accel_wrapper_pkg::line_t       loc_req_data, loc_rsp_data;
    accel_wrapper_pkg::tag_t        loc_req_tag, loc_rsp_tag;
    logic                           loc_rsp_valid, loc_rsp_ready;
    // arbiter to SRAM
    logic                           sram_en, sram_we;
    accel_wrapper_pkg::byteen_t     sram_byteen;
    accel_wrapper_pkg::sram_index_t sram_index;
    accel_wrapper_pkg::line_t       sram_wdata, sram_rdata;

    mem_port_router u_router (.*);

    sram_port_arbiter u_arbiter (.*);

    local_sram u_sram
    (
        .clk    (clk),
        .en     (sram_en),
        .we     (sram_we),
        .byteen (sram_byteen),
        .index  (sram_index),
        .wdata  (sram_wdata),
        .rdata  (sram_rdata)
    );

    ctrl_status_regs u_csr (.*);

endmodule

// ==== test/ext_mem_model.sv ====
`timescale 1ns/100ps

module ext_mem_model
(
    input  logic                            clk,
    input  logic                            nRST,
    input  logic                            req_valid,
    input  logic                            req_rw,
    input  accel_wrapper_pkg::line_addr_t   req_addr,
    input  accel_wrapper_pkg::tag_t         req_tag,
    output logic                            req_ready,
    output logic                            rsp_valid,
    output accel_wrapper_pkg::line_t        rsp_data,
    output accel_wrapper_pkg::tag_t         rsp_tag,
    input  logic                            rsp_ready,
    // cycles to wait before answering, from the testbench
    input  logic [2:0]                      delay
);

    logic       busy;
    logic [2:0] count;

    // one read at a time
    assign req_ready = ~busy;

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            busy      <= 1'b0;
            rsp_valid <= 1'b0;
            count     <= '0;
        end
        else if (!busy)
        begin
            // writes are swallowed
            if (req_valid && !req_rw)
            begin
                busy     <= 1'b1;
                count    <= delay;
                rsp_tag  <= req_tag;
                rsp_data <= {4{4'h0, req_addr}};
            end
        end
        else if (rsp_valid)
        begin
            if (rsp_ready)
            begin
                rsp_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
        else if (count == 0)
            rsp_valid <= 1'b1;
        else
            count <= count - 1'b1;
    end

endmodule

// ==== test/tb_accel_mem_wrapper.sv ====
`timescale 1ns/100ps
`include "accel_wrapper_config.svh"

module tb_accel_mem_wrapper;

    logic clk = 1'b0, nRST = 1'b0;
    logic acc_req_valid, acc_req_rw, acc_req_ready, acc_rsp_valid, acc_rsp_ready;
    accel_wrapper_pkg::byteen_t    acc_req_byteen;
    accel_wrapper_pkg::line_addr_t acc_req_addr;
    accel_wrapper_pkg::line_t      acc_req_data, acc_rsp_data;
    accel_wrapper_pkg::tag_t       acc_req_tag, acc_rsp_tag;
    logic ext_req_valid, ext_req_rw, ext_req_ready, ext_rsp_valid, ext_rsp_ready;
    accel_wrapper_pkg::byteen_t    ext_req_byteen;
    accel_wrapper_pkg::line_addr_t ext_req_addr;
    accel_wrapper_pkg::line_t      ext_req_data, ext_rsp_data;
    accel_wrapper_pkg::tag_t       ext_req_tag, ext_rsp_tag;
    logic mem_host_req_valid, mem_host_req_wen, mem_host_req_ready, mem_host_rsp_valid;
    accel_wrapper_pkg::word_t      mem_host_req_addr, mem_host_req_wdata, mem_host_rsp_rdata;
    accel_wrapper_pkg::strobe_t    mem_host_req_strobe, csr_host_req_strobe;
    logic csr_host_req_valid, csr_host_req_wen, csr_host_req_ready, csr_host_rsp_valid;
    accel_wrapper_pkg::word_t      csr_host_req_addr, csr_host_req_wdata, csr_host_rsp_rdata;
    logic acc_busy, acc_reset;
    accel_wrapper_pkg::word_t      acc_pc_reset_val;
    logic [2:0] ext_delay;

    logic [31:0] lfsr = 32'd66262;
    int error_count = 0, check_count = 0, outstanding = 0;
    bit random_ready = 1'b0;
    string test_name = "reset";
    // expected line and pending flag per tag
    accel_wrapper_pkg::line_t expect_line [256];
    bit pending [256];
    accel_wrapper_pkg::line_t line5, old9, new9, exp9;
    accel_wrapper_pkg::byteen_t be9;
    accel_wrapper_pkg::word_t rd;
    // expected external write
    accel_wrapper_pkg::line_t ext_wr_data;
    accel_wrapper_pkg::byteen_t ext_wr_be;
    bit ext_wr_seen = 1'b0;
    localparam logic [27:0] WIN_LINE = 28'(`ACW_LOCAL_BASE >> 4);

    accel_mem_wrapper uut (.*);

    ext_mem_model ext_model
    (
        .clk(clk), .nRST(nRST), .req_valid(ext_req_valid), .req_rw(ext_req_rw),
        .req_addr(ext_req_addr), .req_tag(ext_req_tag), .req_ready(ext_req_ready),
        .rsp_valid(ext_rsp_valid), .rsp_data(ext_rsp_data), .rsp_tag(ext_rsp_tag),
        .rsp_ready(ext_rsp_ready), .delay(ext_delay)
    );

    always #5 clk = ~clk;

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] next_random(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp, act);
        check_count++;
        assert (exp === act)
        else
        begin
            error_count++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // background drivers and monitor
    ////////////////////////////////////////

    // model delay and response back-pressure
    always @(negedge clk)
    begin
        ext_delay <= next_random(3);
        acc_rsp_ready <= random_ready ? |next_random(2) : 1'b1;
    end

    // every response must match a pending tag
    always @(posedge clk)
    begin
        if (acc_rsp_valid && acc_rsp_ready)
        begin
            assert (pending[acc_rsp_tag])
            else
            begin
                error_count++;
                $display("%s: response with tag %h that was not pending", test_name,
                         acc_rsp_tag);
            end
            check_value({test_name, " rsp data"}, expect_line[acc_rsp_tag], acc_rsp_data);
            pending[acc_rsp_tag] = 1'b0;
            outstanding--;
        end
    end

    // external writes leave with their own enables and data
    always @(posedge clk)
    begin
        if (ext_req_valid && ext_req_ready && ext_req_rw)
        begin
            check_value({test_name, " ext byteen"}, ext_wr_be, ext_req_byteen);
            check_value({test_name, " ext data"}, ext_wr_data, ext_req_data);
            ext_wr_seen = 1'b1;
        end
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic acc_send(input logic rw, input logic [27:0] addr, input logic [15:0] be,
                            input logic [127:0] data, input logic [7:0] tag,
                            input logic [127:0] exp);
        @(negedge clk);
        if (!rw)
        begin
            expect_line[tag] = exp;
            pending[tag] = 1'b1;
            outstanding++;
        end
        acc_req_valid = 1'b1;
        acc_req_rw = rw;
        acc_req_addr = addr;
        acc_req_byteen = be;
        acc_req_data = data;
        acc_req_tag = tag;
        do
            @(posedge clk);
        while (!acc_req_ready);
        @(negedge clk);
        acc_req_valid = 1'b0;
    endtask

    // one host access, port picked by csr
    task automatic host_access(input bit csr, input logic wen, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strobe,
                               output logic [31:0] rdata);
        @(negedge clk);
        if (csr)
        begin
            {csr_host_req_valid, csr_host_req_wen} = {1'b1, wen};
            {csr_host_req_addr, csr_host_req_wdata, csr_host_req_strobe} = {addr, wdata, strobe};
        end
        else
        begin
            {mem_host_req_valid, mem_host_req_wen} = {1'b1, wen};
            {mem_host_req_addr, mem_host_req_wdata, mem_host_req_strobe} = {addr, wdata, strobe};
        end
        do
            @(posedge clk);
        while (!(csr ? csr_host_req_ready : mem_host_req_ready));
        @(negedge clk);
        csr_host_req_valid = 1'b0;
        mem_host_req_valid = 1'b0;
        // read data one cycle after acceptance
        if (!wen)
        begin
            assert (csr ? csr_host_rsp_valid : mem_host_rsp_valid)
            else
            begin
                error_count++;
                $display("%s: host read gave no response", test_name);
            end
            rdata = csr ? csr_host_rsp_rdata : mem_host_rsp_rdata;
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial
    begin
        {acc_req_valid, acc_req_rw, acc_req_byteen, acc_req_addr} = '0;
        {acc_req_data, acc_req_tag, acc_rsp_ready, ext_delay} = '0;
        {mem_host_req_valid, mem_host_req_wen, mem_host_req_addr} = '0;
        {mem_host_req_wdata, mem_host_req_strobe} = '0;
        {csr_host_req_valid, csr_host_req_wen, csr_host_req_addr} = '0;
        {csr_host_req_wdata, csr_host_req_strobe, acc_busy} = '0;
        repeat (16) @(negedge clk);
        nRST = 1'b1;
        check_value("reset acc_reset", 1, acc_reset);
        host_access(1, 0, `ACW_CSR_PC_OFS, 0, 0, rd);
        check_value("reset pc", `ACW_PC_RESET_DEFAULT, rd);

        // host words land in lanes, acc reads whole line
        test_name = "host_to_acc";
        for (int i = 0; i < 4; i++)
        begin
            line5.words[i] = next_random(32);
            host_access(0, 1, 32'h50 + i * 4, line5.words[i], 4'hF, rd);
        end
        acc_send(0, WIN_LINE + 5, 0, 0, 8'h11, line5);

        // acc byte-enabled write, host reads back merged
        test_name = "acc_to_host";
        for (int i = 0; i < 4; i++)
        begin
            old9.words[i] = next_random(32);
            new9.words[i] = next_random(32);
            host_access(0, 1, 32'h90 + i * 4, old9.words[i], 4'hF, rd);
        end
        be9 = next_random(16);
        for (int b = 0; b < 16; b++)
            exp9.raw[b*8 +: 8] = be9[b] ? new9.raw[b*8 +: 8] : old9.raw[b*8 +: 8];
        acc_send(1, WIN_LINE + 9, be9, new9, 8'h22, 0);
        for (int i = 0; i < 4; i++)
        begin
            host_access(0, 0, 32'h90 + i * 4, 0, 0, rd);
            check_value("acc_to_host word", exp9.words[i], rd);
        end

        // outside the window goes to the model
        test_name = "external";
        for (int i = 0; i < 4; i++)
            acc_send(0, 28'h12_3400 + i, 0, 0, 8'h30 + i, {4{4'h0, 28'(28'h12_3400 + i)}});
        while (outstanding != 0)
            @(negedge clk);

        // writes leave on the external port unchanged
        ext_wr_be = next_random(16);
        for (int i = 0; i < 4; i++)
            ext_wr_data.words[i] = next_random(32);
        acc_send(1, 28'h12_3500, ext_wr_be, ext_wr_data, 8'h3F, 0);
        check_value("external write seen", 1, ext_wr_seen);

        // mixed targets under back-pressure
        test_name = "interleaved";
        random_ready = 1'b1;
        for (int i = 0; i < 24; i++)
        begin
            if (i % 2 == 0)
                acc_send(0, WIN_LINE + 5, 0, 0, 8'h40 + i, line5);
            else
                acc_send(0, 28'h0AB_0000 + i, 0, 0, 8'h40 + i,
                         {4{4'h0, 28'(28'h0AB_0000 + i)}});
        end
        while (outstanding != 0)
            @(negedge clk);
        random_ready = 1'b0;

        // registers and run control
        test_name = "csr";
        host_access(1, 1, `ACW_CSR_PC_OFS, 32'h1234_5678, 4'b0101, rd);
        host_access(1, 0, `ACW_CSR_PC_OFS, 0, 0, rd);
        check_value("csr pc merge", 32'hF034_0078, rd);
        check_value("csr pc output", 32'hF034_0078, acc_pc_reset_val);
        @(negedge clk);
        acc_busy = 1'b1;
        @(negedge clk);
        host_access(1, 0, `ACW_CSR_BUSY_OFS, 0, 0, rd);
        check_value("csr busy", 1, rd);
        host_access(1, 1, `ACW_CSR_START_OFS, 1, 4'h1, rd);
        check_value("csr start", 0, acc_reset);
        acc_busy = 1'b0;
        repeat (2) @(negedge clk);
        check_value("csr busy fall", 1, acc_reset);

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // roughly twice the summed test time
    initial
    begin
        #40000;
        $display("watchdog expired in test %s, run did not finish", test_name);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
rtl/accel_wrapper_pkg.sv
rtl/local_sram.sv
rtl/mem_port_router.sv
rtl/sram_port_arbiter.sv
rtl/ctrl_status_regs.sv
rtl/accel_mem_wrapper.sv
test/ext_mem_model.sv
test/tb_accel_mem_wrapper.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_accel_mem_wrapper -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
